// File: sources.f
rtl/obj_pkg.sv
rtl/obj_video_timer.sv
rtl/obj_regs.sv
rtl/obj_ram.sv
rtl/obj_dma.sv
rtl/obj_dma_top.sv
testbench/obj_tb.sv

// File: testbench/obj_tb.sv
// ####################################################################
// sprite DMA testbench: random table, frame and trigger copies,
// buffer compared against a priority copy model
// ####################################################################

module obj_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import obj_pkg::*;

    localparam int frame_clks = h_total * v_total * 2;    // pxl2_cen is half rate
    localparam int wait_limit = 2 * frame_clks;
    localparam int tbl_words  = 4096;                     // 512 entries of 8 words

    logic       clk, rst;
    logic       cpu_ram_we, cpu_reg_we;
    spr_addr_t  cpu_addr;
    logic [1:0] cpu_reg_addr;
    spr_word_t  cpu_din;
    buf_addr_t  obj_rd_addr;
    buf_word_t  obj_rd_data;
    logic       dma_bsy, flicker;

    integer     seed;
    int         errors, tests, errs0, t_fast, t_slow;
    logic       saw, saw_any;
    spr_word_t  tbl_model [tbl_words];
    spr_word_t  buf_model [2048];    // sprite words, even ones in the low lane

    obj_dma_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .cpu_ram_we   (cpu_ram_we),
        .cpu_addr     (cpu_addr),
        .cpu_reg_we   (cpu_reg_we),
        .cpu_reg_addr (cpu_reg_addr),
        .cpu_din      (cpu_din),
        .obj_rd_addr  (obj_rd_addr),
        .obj_rd_data  (obj_rd_data),
        .dma_bsy      (dma_bsy),
        .flicker      (flicker)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_buf(input string name, input buf_word_t got, input buf_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t, %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t, %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("%s after %0d clks", what, wait_limit);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errs0) ? "ok" : "failed");
    endtask

    task automatic write_reg(input logic [1:0] addr, input spr_word_t data);
        @(negedge clk);
        cpu_reg_we   = 1'b1;
        cpu_reg_addr = addr;
        cpu_din      = data;
        @(negedge clk);
        cpu_reg_we   = 1'b0;    // register updated at the posedge in between
    endtask

    // word 0 of each entry gets a skewed priority so slots collide often
    task automatic fill_table();
        integer     r, r2;
        logic [7:0] pri;
        logic       vis;
        for (int i = 0; i < tbl_words; i++) begin
            r = $random(seed);
            if (i % 8 == 0) begin
                r2  = $random(seed);
                pri = r[8] ? {4'h0, r[3:0]} : r[7:0];    // half land on slots 0..15
                vis = (r[10:9] != 2'b00);                 // three in four visible
                tbl_model[i] = {vis, r2[6:0], pri};
            end else begin
                tbl_model[i] = r[15:0];
            end
            @(negedge clk);
            cpu_ram_we = 1'b1;
            cpu_addr   = 13'(i);
            cpu_din    = tbl_model[i];
        end
        @(negedge clk);
        cpu_ram_we = 1'b0;
    endtask

    // clear, then visible entries in table order, later ones win a slot
    task automatic apply_copy_rule(input logic k44, input logic skip);
        int         n_clr, n_ent, slot;
        logic [7:0] pri;
        spr_word_t  w0;
        n_clr = k44 ? 1024 : 2048;    // 44 leaves the upper half untouched
        n_ent = k44 ? 256 : 512;
        for (int i = 0; i < n_clr; i++) buf_model[i] = '0;
        for (int e = 0; e < n_ent; e++) begin
            w0  = tbl_model[e*8];
            pri = w0[7:0];
            if (w0[15] && (!skip || pri != 8'd0)) begin
                slot = k44 ? (128 - pri[6:0]) % 128 : pri;    // negated 7-bit slot
                for (int k = 0; k < 7; k++) buf_model[slot*8 + k] = tbl_model[e*8 + k];
            end
        end
    endtask

    task automatic compare_buffer();
        buf_word_t exp;
        for (int i = 0; i < 1024; i++) begin
            @(negedge clk);
            obj_rd_addr = 10'(i);
            @(negedge clk);    // one clk read latency
            exp = {buf_model[2*i+1], buf_model[2*i]};
            check_buf($sformatf("obj_rd_data[%0d]", i), obj_rd_data, exp);
        end
    endtask

    task automatic wait_bsy(input logic level, output int clks);
        clks = 0;
        while (dma_bsy !== level && clks < wait_limit) begin
            @(negedge clk);
            clks++;
        end
        if (dma_bsy !== level) begin
            stop_on_timeout($sformatf("dma_bsy never went to %0b", level));
        end
    endtask

    task automatic wait_flicker(output logic saw_bsy);
        logic old;
        int   n;
        old     = flicker;
        saw_bsy = 1'b0;
        n       = 0;
        while (flicker === old && n < wait_limit) begin
            @(negedge clk);
            saw_bsy = saw_bsy | dma_bsy;
            n++;
        end
        if (flicker === old) begin
            stop_on_timeout("flicker never toggled");
        end
    endtask

    // one copy by frame start or by trigger, then the whole buffer is checked
    task automatic run_copy(input logic [3:0] ctrl, input logic use_trig, output int bsy_clks);
        logic old_flk;
        int   rise_clks;
        write_reg(reg_ctrl, {12'h0, ctrl});
        old_flk = flicker;
        if (use_trig) write_reg(reg_trig, 16'h0);
        wait_bsy(1'b1, rise_clks);
        check_flag("flicker", flicker, ~old_flk);    // toggles with the start
        if (use_trig) check_flag("dma_bsy within 16 clks of trigger", rise_clks < 16, 1'b1);
        wait_bsy(1'b0, bsy_clks);
        write_reg(reg_ctrl, 16'h0);    // no further frame copies
        apply_copy_rule(ctrl[ctrl_k44_bit], ctrl[ctrl_skip0_bit]);
        compare_buffer();
    endtask

    initial begin
        seed         = 32'h4725_c137;
        errors       = 0;
        tests        = 0;
        rst          = 1'b1;
        cpu_ram_we   = 1'b0;
        cpu_addr     = '0;
        cpu_reg_we   = 1'b0;
        cpu_reg_addr = '0;
        cpu_din      = '0;
        obj_rd_addr  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs0 = errors;
        check_flag("dma_bsy", dma_bsy, 1'b0);
        check_flag("flicker", flicker, 1'b0);
        fill_table();
        wait_flicker(saw);
        saw_any = saw;
        check_flag("flicker", flicker, 1'b1);
        wait_flicker(saw);
        saw_any = saw_any | saw;
        check_flag("flicker", flicker, 1'b0);
        check_flag("dma_bsy", saw_any, 1'b0);    // frames with DMA disabled
        end_test("reset and idle frames");

        errs0 = errors;
        run_copy(4'b0010, 1'b0, t_fast);
        end_test("frame copy 46 layout");

        // upper half keeps the 46 result in both DUT and model
        errs0 = errors;
        run_copy(4'b0110, 1'b0, t_fast);
        end_test("frame copy 44 layout");

        errs0 = errors;
        run_copy(4'b1010, 1'b0, t_fast);
        end_test("skip0 set");

        errs0 = errors;
        fill_table();    // fresh table, the trigger copy has to rewrite the buffer
        run_copy(4'b0000, 1'b1, t_fast);
        fill_table();    // and again for the slow copy
        run_copy(4'b0001, 1'b1, t_slow);
        if (t_slow <= t_fast) begin
            errors++;
            $display("slow mode busy time %0d clks is not longer than fast mode %0d clks",
                     t_slow, t_fast);
        end
        end_test("trigger fast and slow mode");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: rtl/obj_dma_top.sv
// ####################################################################
// sprite DMA subsystem top: timer, registers, table and buffer RAMs
// ####################################################################

module obj_dma_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_ram_we,
    input  obj_pkg::spr_addr_t  cpu_addr,
    input  logic                cpu_reg_we,
    input  logic [1:0]          cpu_reg_addr,
    input  obj_pkg::spr_word_t  cpu_din,
    input  obj_pkg::buf_addr_t  obj_rd_addr,
    output obj_pkg::buf_word_t  obj_rd_data,
    output logic                dma_bsy,
    output logic                flicker
);
    import obj_pkg::*;

    logic        pxl2_cen, hs, vs;
    logic        mode8, dma_en, k44_en, skip0, dma_trig;
    spr_addr_t   dma_addr;
    spr_word_t   dma_data, dma_din;
    logic        dma_weh, dma_wel;
    logic [10:0] dma_wr_addr;    // sprite word address in the buffer

    obj_video_timer u_timer (
        .clk      (clk),
        .rst      (rst),
        .pxl2_cen (pxl2_cen),
        .hs       (hs),
        .vs       (vs)
    );

    obj_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .cpu_reg_we   (cpu_reg_we),
        .cpu_reg_addr (cpu_reg_addr),
        .cpu_din      (cpu_din),
        .mode8        (mode8),
        .dma_en       (dma_en),
        .k44_en       (k44_en),
        .skip0        (skip0),
        .dma_trig     (dma_trig)
    );

    obj_dma u_dma (
        .clk         (clk),
        .rst         (rst),
        .pxl2_cen    (pxl2_cen),
        .mode8       (mode8),
        .dma_en      (dma_en),
        .dma_trig    (dma_trig),
        .k44_en      (k44_en),
        .skip0       (skip0),
        .hs          (hs),
        .vs          (vs),
        .dma_addr    (dma_addr),
        .dma_data    (dma_data),
        .dma_bsy     (dma_bsy),
        .dma_weh     (dma_weh),
        .dma_wel     (dma_wel),
        .dma_wr_addr (dma_wr_addr),
        .dma_din     (dma_din),
        .flicker     (flicker)
    );

    // sprite table, CPU writes, DMA reads
    obj_ram #(.aw(13), .lanes(1)) u_table (
        .clk     (clk),
        .we      (cpu_ram_we),
        .wr_addr (cpu_addr),
        .wr_data (cpu_din),
        .rd_addr (dma_addr),
        .rd_data (dma_data)
    );

    // sprite buffer, odd sprite words in the high lane
    obj_ram #(.aw(10), .lanes(2)) u_buf (
        .clk     (clk),
        .we      ({dma_weh, dma_wel}),
        .wr_addr (dma_wr_addr[10:1]),
        .wr_data ({dma_din, dma_din}),
        .rd_addr (obj_rd_addr),
        .rd_data (obj_rd_data)
    );

endmodule

// File: rtl/obj_dma.sv
// ####################################################################
// frame sprite DMA: clears the buffer then copies visible table
// entries into the buffer slot picked by their priority byte
// ####################################################################

module obj_dma (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl2_cen,
    input  logic                mode8,
    input  logic                dma_en,
    input  logic                dma_trig,
    input  logic                k44_en,     // 44 layout, else 46
    input  logic                skip0,
    input  logic                hs,
    input  logic                vs,
    // sprite table read port
    output obj_pkg::spr_addr_t  dma_addr,
    input  obj_pkg::spr_word_t  dma_data,
    // sprite buffer write port
    output logic                dma_bsy,
    output logic                dma_weh,
    output logic                dma_wel,
    output logic [10:0]         dma_wr_addr,
    output obj_pkg::spr_word_t  dma_din,
    output logic                flicker
);
    import obj_pkg::*;

    logic        hsl, hs_pos, frame_start;
    logic [1:0]  vs_sh;       // [1] vs at previous hs edge, [0] vs now
    logic        trig_pend;   // manual trigger waiting for busy
    logic        dma_clr, dma_wait, dma_ok, dma_last;
    logic        dma_we, scan_step;
    logic [10:0] dma_bufa;    // buffer sprite word being written
    spr_word_t   dma_bufd;    // table word one step behind the read
    logic [6:0]  neg_pri;     // 44 layout slot

    assign hs_pos      = hs & ~hsl;
    assign frame_start = hs_pos && (vs_sh == 2'b10);    // first line after vs
    assign neg_pri     = 7'd0 - dma_data[6:0];          // 44 slots run backwards

    assign scan_step = pxl2_cen & dma_bsy & ~dma_clr & ~dma_wait & ~dma_last;

    // buffer port, clear writes zeros through the address counter
    assign dma_we      = dma_clr | dma_ok;
    assign dma_wr_addr = dma_clr ? dma_addr[10:0] : dma_bufa;
    assign dma_din     = dma_clr ? 16'h0 : dma_bufd;
    assign dma_wel     = dma_we & ~dma_wr_addr[0];    // even words low lane
    assign dma_weh     = dma_we &  dma_wr_addr[0];

    // trigger pulses may land between enables
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_pend <= 1'b0;
        end else begin
            if (dma_bsy)  trig_pend <= 1'b0;
            if (dma_trig) trig_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsl      <= 1'b0;
            vs_sh    <= '0;
            flicker  <= 1'b0;
            dma_bsy  <= 1'b0;
            dma_clr  <= 1'b0;
            dma_wait <= 1'b0;
            dma_ok   <= 1'b0;
            dma_last <= 1'b0;
            dma_addr <= '0;
        end else if (pxl2_cen) begin
            hsl      <= hs;
            vs_sh[0] <= vs;
            if (hs_pos) vs_sh[1] <= vs_sh[0];
            if (!dma_bsy) begin
                dma_ok   <= 1'b0;
                dma_clr  <= 1'b0;
                dma_wait <= 1'b0;
                dma_last <= 1'b0;
                dma_addr <= '0;
                if (frame_start || trig_pend) begin
                    flicker <= ~flicker;    // every frame, DMA or not
                    if (dma_en || trig_pend) begin
                        dma_bsy  <= 1'b1;
                        dma_clr  <= 1'b1;
                        dma_wait <= mode8 && !k44_en;    // 8-bit speed
                    end
                end
            end else if (dma_clr) begin
                // 2048 words in 46 layout, 1024 in 44
                dma_addr[10:0] <= dma_addr[10:0] + 11'd1;
                dma_clr        <= ~&{dma_addr[10] | k44_en, dma_addr[9:0]};
                if (k44_en) dma_addr[10] <= 1'b0;
                if (&dma_addr[10:0] && dma_wait) dma_addr[10:0] <= wait_reload;
            end else if (dma_wait) begin
                // idle until the low counter wraps, lands back on 0
                {dma_wait, dma_addr[10:0]} <= {1'b1, dma_addr[10:0]} + 12'd1;
            end else if (dma_last) begin
                // word 6 of the last entry went out during this step
                dma_bsy  <= 1'b0;
                dma_ok   <= 1'b0;
                dma_last <= 1'b0;
            end else begin
                if (dma_addr[2:0] == 3'd0) begin
                    // word 0 decides visibility for the whole entry
                    dma_ok <= dma_data[15] && (dma_data[7:0] != 8'd0 || !skip0);
                end
                if (dma_addr[2:0] == 3'd6) begin
                    dma_addr <= dma_addr + 13'd2;    // word 7 not copied
                    dma_last <= k44_en ? &dma_addr[10:3] : &dma_addr[11:3];
                end else begin
                    dma_addr <= dma_addr + 13'd1;
                end
            end
        end
    end

    // payload side of the scan, one step behind the table read
    always_ff @(posedge clk) begin
        if (scan_step) begin
            dma_bufd      <= dma_data;
            dma_bufa[2:0] <= dma_addr[2:0];
            if (dma_addr[2:0] == 3'd0) begin
                dma_bufa[10:3] <= k44_en ? {1'b0, neg_pri} : dma_data[7:0];
            end
        end
    end

    // the last write of the scan must still be inside the busy window
    a_we_in_bsy: assert property (@(posedge clk) disable iff (rst)
        (dma_weh || dma_wel) |-> dma_bsy);

    a_one_lane: assert property (@(posedge clk) disable iff (rst)
        !(dma_weh && dma_wel));

endmodule

// File: rtl/obj_ram.sv
// ####################################################################
// dual port RAM, 16-bit write lanes, registered read port
// ####################################################################

module obj_ram #(
    parameter int aw    = 10,    // address bits
    parameter int lanes = 2      // 16-bit lanes per word
) (
    input  logic                                         clk,
    // write side
    input  logic [lanes-1:0]                             we,
    input  logic [aw-1:0]                                wr_addr,
    input  logic [lanes*$bits(obj_pkg::spr_word_t)-1:0]  wr_data,
    // read side
    input  logic [aw-1:0]                                rd_addr,
    output logic [lanes*$bits(obj_pkg::spr_word_t)-1:0]  rd_data
);
    import obj_pkg::*;

    localparam int lw = $bits(spr_word_t);    // lane width

    logic [lanes*lw-1:0] mem [2**aw];

    // lane 0 is the low half of the word
    always_ff @(posedge clk) begin
        for (int i = 0; i < lanes; i++) begin
            if (we[i]) begin
                mem[wr_addr][i*lw +: lw] <= wr_data[i*lw +: lw];
            end
        end
    end

    // read during write returns the old contents
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // a write to an unknown address would corrupt the whole array in sim
    a_wr_addr_known: assert property (@(posedge clk)
        (|we) |-> !$isunknown(wr_addr));

endmodule

// File: rtl/obj_regs.sv
// ####################################################################
// CPU control registers: mode bits and the manual DMA trigger pulse
// ####################################################################

module obj_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_reg_we,
    input  logic [1:0]          cpu_reg_addr,
    input  obj_pkg::spr_word_t  cpu_din,
    output logic                mode8,
    output logic                dma_en,
    output logic                k44_en,
    output logic                skip0,
    output logic                dma_trig
);
    import obj_pkg::*;

    logic [3:0] ctrl;    // control register, only the low nibble exists
    logic       trig_wr;

    assign trig_wr = cpu_reg_we && (cpu_reg_addr == reg_trig);    // data ignored

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl     <= '0;
            dma_trig <= 1'b0;
        end else begin
            if (cpu_reg_we && cpu_reg_addr == reg_ctrl) begin
                ctrl <= cpu_din[3:0];
            end
            dma_trig <= trig_wr;    // one clk after the write
        end
    end

    assign mode8  = ctrl[ctrl_mode8_bit];
    assign dma_en = ctrl[ctrl_en_bit];
    assign k44_en = ctrl[ctrl_k44_bit];
    assign skip0  = ctrl[ctrl_skip0_bit];

    // the DMA latches the trigger, a single clk is all it needs
    a_trig_pulse: assert property (@(posedge clk) disable iff (rst)
        dma_trig |=> !dma_trig);

endmodule

// File: rtl/obj_video_timer.sv
// ####################################################################
// video timer: half rate pixel enable, line/frame counters, hs and vs
// ####################################################################

module obj_video_timer (
    input  logic clk,
    input  logic rst,
    output logic pxl2_cen,
    output logic hs,
    output logic vs
);
    import obj_pkg::*;

    logic [8:0] hcnt;    // pixel in line
    logic [8:0] vcnt;    // line in frame

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl2_cen <= 1'b0;
            hcnt     <= '0;
            vcnt     <= '0;
        end else begin
            pxl2_cen <= ~pxl2_cen;    // high every second clk
            if (pxl2_cen) begin
                if (hcnt == 9'(h_total - 1)) begin
                    hcnt <= '0;
                    // next line, wrap at frame end
                    if (vcnt == 9'(v_total - 1)) begin
                        vcnt <= '0;
                    end else begin
                        vcnt <= vcnt + 9'd1;
                    end
                end else begin
                    hcnt <= hcnt + 9'd1;
                end
            end
        end
    end

    // sync windows, both active high
    assign hs = (hcnt >= 9'(h_sync_start)) && (hcnt < 9'(h_sync_start + h_sync_len));
    assign vs = (vcnt >= 9'(v_sync_start)) && (vcnt < 9'(v_sync_start + v_sync_len));

    // vs changes only at line start, well away from the hs rising edge
    // which the DMA samples it on

endmodule

// File: rtl/obj_pkg.sv
// ####################################################################
// sprite DMA shared definitions: word and address types, register map,
// control bit positions and video timing constants
// ####################################################################

package obj_pkg;

    // sprite table side
    typedef logic [15:0] spr_word_t;    // one table word
    typedef logic [12:0] spr_addr_t;    // word address, 16 kB

    // sprite buffer side, two sprite words per buffer word
    typedef logic [31:0] buf_word_t;
    typedef logic [9:0]  buf_addr_t;    // 1024 buffer words

    // horizontal timing in pixels
    localparam int h_total      = 384;
    localparam int h_sync_start = 320;
    localparam int h_sync_len   = 32;

    // vertical timing in lines
    localparam int v_total      = 264;
    localparam int v_sync_start = 240;
    localparam int v_sync_len   = 8;

    // register map
    localparam logic [1:0] reg_ctrl = 2'd0;
    localparam logic [1:0] reg_trig = 2'd1;    // any write fires a copy

    // control register bits
    localparam int ctrl_mode8_bit = 0;    // 8-bit bus speed
    localparam int ctrl_en_bit    = 1;    // frame DMA enable
    localparam int ctrl_k44_bit   = 2;    // 44 layout
    localparam int ctrl_skip0_bit = 3;    // drop priority 0 entries

    // slow mode restarts the low counter here after the clear
    localparam logic [10:0] wait_reload = 11'h218;

endpackage
